/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_padcfg and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_padcfg -Mdir obj_dir
	./obj_dir/Vtb_padcfg +verilator+error+limit+1000 | tee sim.log
	@grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
+incdir+rtl
rtl/padcfg_pkg.sv
rtl/padcfg_regs.sv
rtl/padcfg_serial_loader.sv
rtl/padcfg_wb_top.sv
testbench/padcfg_checker.sv
testbench/padcfg_monitor.sv
testbench/tb_padcfg.sv

/* rtl/padcfg_defines.svh */
// Fixed sizes and register map of the pad configuration block
// Included by the package and by every module that needs a size or an offset
`ifndef PADCFG_DEFINES_SVH
`define PADCFG_DEFINES_SVH

// Pad ring, split into two serial chains of equal length
`define PADCFG_IO_PADS      12
`define PADCFG_IO_PADS_LOW  6
`define PADCFG_PWR_PADS     4
`define PADCFG_CTRL_BITS    13

// Register map, the block answers on one 256-byte window
`define PADCFG_BASE_HI      24'h230000
`define PADCFG_OFS_XFER     8'h00
`define PADCFG_OFS_PWR      8'h04
`define PADCFG_OFS_IRQ      8'h08
`define PADCFG_OFS_IODATA   8'h0c
`define PADCFG_OFS_IOCFG    8'h24

// Reset control words for bidirectional and input-only pads
`define PADCFG_CTRL_BIDIR   13'h1803
`define PADCFG_CTRL_INPUT   13'h0403
`define PADCFG_OEB_BIT      1
`define PADCFG_INP_DIS_BIT  3

`endif

/* rtl/padcfg_pkg.sv */
// Shared types of the pad configuration block
// Referenced by scoped name from the RTL and the testbench
`include "padcfg_defines.svh"

package padcfg_pkg;

    // One control word as shifted into a pad
    typedef logic [`PADCFG_CTRL_BITS-1:0] io_ctrl_t;

    // One bit per user pad
    typedef logic [`PADCFG_IO_PADS-1:0] pad_vec_t;

    typedef logic [`PADCFG_PWR_PADS-1:0] pwr_ctrl_t;
    typedef logic [2:0] irq_ena_t;

    // Bus request as seen by the register file
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } reg_req_t;

    // Serial loader sequencing
    typedef enum logic [1:0] {
        IDLE,
        START,
        SHIFT,
        LOAD
    } loader_state_t;

endpackage

/* rtl/padcfg_regs.sv */
// Register file of the pad configuration block
// Decodes bus requests, holds every configuration register and issues the
// start pulse for the serial loader
`timescale 1ns/10ps
`include "padcfg_defines.svh"

module padcfg_regs (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  padcfg_pkg::reg_req_t                        req_i,
    input  logic                                        busy_i,
    input  padcfg_pkg::pad_vec_t                        mgmt_gpio_in_i,
    output logic [31:0]                                 rdata_o,
    output logic                                        ack_o,
    output logic                                        start_o,
    output padcfg_pkg::io_ctrl_t [`PADCFG_IO_PADS-1:0]  io_ctrl_o,
    output padcfg_pkg::pad_vec_t                        mgmt_gpio_out_o,
    output padcfg_pkg::pad_vec_t                        mgmt_gpio_oe_o,
    output padcfg_pkg::pwr_ctrl_t                       pwr_ctrl_o,
    output padcfg_pkg::irq_ena_t                        user_irq_ena_o,
    output logic                                        jtag_oenb_o,
    output logic                                        sdo_oenb_o,
    output logic                                        flash_io2_oenb_o,
    output logic                                        flash_io3_oenb_o
);

    logic [7:0] ofs;
    logic hit;
    logic wr;
    logic xfer_sel;
    logic pwr_sel;
    logic irq_sel;
    logic iodata_sel;
    padcfg_pkg::pad_vec_t cfg_sel;
    logic [31:0] rdata_pre;

    padcfg_pkg::pwr_ctrl_t pwr_q;
    padcfg_pkg::irq_ena_t irq_q;
    padcfg_pkg::pad_vec_t gpio_out_q;
    padcfg_pkg::io_ctrl_t [`PADCFG_IO_PADS-1:0] io_ctrl_q;

    // A request is served once, ack masks the cycle it is still held
    assign hit = req_i.valid && !ack_o && (req_i.addr[31:8] == `PADCFG_BASE_HI);
    assign wr  = hit && req_i.write;
    assign ofs = req_i.addr[7:0];

    assign xfer_sel   = (ofs == `PADCFG_OFS_XFER);
    assign pwr_sel    = (ofs == `PADCFG_OFS_PWR);
    assign irq_sel    = (ofs == `PADCFG_OFS_IRQ);
    assign iodata_sel = (ofs == `PADCFG_OFS_IODATA);

    // Per-pad word select and output enable from the input-disable bit
    for (genvar i = 0; i < `PADCFG_IO_PADS; i++) begin : g_pad
        assign cfg_sel[i] = (ofs == 8'(`PADCFG_OFS_IOCFG + 4 * i));
        assign mgmt_gpio_oe_o[i] = io_ctrl_q[i][`PADCFG_INP_DIS_BIT];
    end

    // Readback, unmapped offsets give zero
    always_comb begin
        rdata_pre = '0;
        if (xfer_sel) begin
            rdata_pre = {31'b0, busy_i};
        end else if (pwr_sel) begin
            rdata_pre = 32'(pwr_q);
        end else if (irq_sel) begin
            rdata_pre = 32'(irq_q);
        end else if (iodata_sel) begin
            rdata_pre = 32'(mgmt_gpio_in_i);
        end else begin
            for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
                if (cfg_sel[i]) begin
                    rdata_pre = 32'(io_ctrl_q[i]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            rdata_o <= rdata_pre;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack_o      <= 1'b0;
            start_o    <= 1'b0;
            pwr_q      <= '0;
            irq_q      <= '0;
            gpio_out_q <= '0;
        end else begin
            ack_o <= hit;
            // Start is a single-cycle pulse, dropped while a transfer runs
            start_o <= wr && xfer_sel && req_i.wdata[0] && !busy_i;
            if (wr && pwr_sel) begin
                pwr_q <= req_i.wdata[`PADCFG_PWR_PADS-1:0];
            end
            if (wr && irq_sel) begin
                irq_q <= req_i.wdata[$bits(padcfg_pkg::irq_ena_t)-1:0];
            end
            if (wr && iodata_sel) begin
                gpio_out_q <= req_i.wdata[`PADCFG_IO_PADS-1:0];
            end
        end
    end

    // Pad control words, the two pads at each end of the ring start bidirectional
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
                if ((i < 2) || (i >= `PADCFG_IO_PADS - 2)) begin
                    io_ctrl_q[i] <= `PADCFG_CTRL_BIDIR;
                end else begin
                    io_ctrl_q[i] <= `PADCFG_CTRL_INPUT;
                end
            end
        end else begin
            for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
                if (wr && cfg_sel[i]) begin
                    io_ctrl_q[i] <= req_i.wdata[`PADCFG_CTRL_BITS-1:0];
                end
            end
        end
    end

    assign io_ctrl_o       = io_ctrl_q;
    assign mgmt_gpio_out_o = gpio_out_q;
    assign pwr_ctrl_o      = pwr_q;
    assign user_irq_ena_o  = irq_q;

    // OEB state of the pads whose default function the core may override
    assign jtag_oenb_o      = io_ctrl_q[0][`PADCFG_OEB_BIT];
    assign sdo_oenb_o       = io_ctrl_q[1][`PADCFG_OEB_BIT];
    assign flash_io2_oenb_o = io_ctrl_q[`PADCFG_IO_PADS-2][`PADCFG_OEB_BIT];
    assign flash_io3_oenb_o = io_ctrl_q[`PADCFG_IO_PADS-1][`PADCFG_OEB_BIT];

endmodule

/* rtl/padcfg_serial_loader.sv */
// Serial loader for the pad control words
// Shifts both halves of the pad ring out in parallel, MSB first, then
// pulses the chain load strobe while the serial clock is held high
`timescale 1ns/10ps
`include "padcfg_defines.svh"

module padcfg_serial_loader (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  logic                                        start_i,
    input  padcfg_pkg::io_ctrl_t [`PADCFG_IO_PADS-1:0]  io_ctrl_i,
    output logic                                        busy_o,
    output logic                                        serial_clock_o,
    output logic                                        serial_resetn_o,
    output logic                                        serial_data_1_o,
    output logic                                        serial_data_2_o
);

    localparam int PAD_CNT_W  = $clog2(`PADCFG_IO_PADS_LOW);
    localparam int PAD_IDX_W  = $clog2(`PADCFG_IO_PADS);
    localparam int CYC_CNT_W  = $clog2(2 * `PADCFG_CTRL_BITS);
    localparam int SHIFT_LAST = 2 * `PADCFG_CTRL_BITS - 1;
    localparam int LOAD_LAST  = 3;

    padcfg_pkg::loader_state_t state;
    logic [PAD_CNT_W-1:0] pad_cnt;
    logic [CYC_CNT_W-1:0] cyc_cnt;
    logic [PAD_IDX_W-1:0] idx_1;
    logic [PAD_IDX_W-1:0] idx_2;
    logic last_pad;
    padcfg_pkg::io_ctrl_t stage_1;
    padcfg_pkg::io_ctrl_t stage_2;

    // Chain 1 runs from the middle of the ring down, chain 2 from the middle up
    // Both chains must hold the same number of pads
    assign idx_1 = PAD_IDX_W'(`PADCFG_IO_PADS_LOW - 1) - PAD_IDX_W'(pad_cnt);
    assign idx_2 = PAD_IDX_W'(`PADCFG_IO_PADS_LOW) + PAD_IDX_W'(pad_cnt);
    assign last_pad = (pad_cnt == PAD_CNT_W'(`PADCFG_IO_PADS_LOW - 1));

    assign busy_o          = (state != padcfg_pkg::IDLE);
    assign serial_data_1_o = stage_1[`PADCFG_CTRL_BITS-1];
    assign serial_data_2_o = stage_2[`PADCFG_CTRL_BITS-1];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state           <= padcfg_pkg::IDLE;
            pad_cnt         <= '0;
            cyc_cnt         <= '0;
            serial_clock_o  <= 1'b0;
            serial_resetn_o <= 1'b0;
        end else begin
            case (state)
                padcfg_pkg::IDLE: begin
                    serial_clock_o  <= 1'b0;
                    serial_resetn_o <= 1'b1;
                    pad_cnt         <= '0;
                    if (start_i) begin
                        state <= padcfg_pkg::START;
                    end
                end
                padcfg_pkg::START: begin
                    serial_clock_o <= 1'b0;
                    cyc_cnt        <= '0;
                    state          <= padcfg_pkg::SHIFT;
                end
                padcfg_pkg::SHIFT: begin
                    // First cycle gives the new MSB a full low phase
                    if (cyc_cnt != '0) begin
                        serial_clock_o <= ~serial_clock_o;
                    end
                    if (cyc_cnt == CYC_CNT_W'(SHIFT_LAST)) begin
                        cyc_cnt <= '0;
                        if (last_pad) begin
                            state <= padcfg_pkg::LOAD;
                        end else begin
                            pad_cnt <= pad_cnt + 1'b1;
                            state   <= padcfg_pkg::START;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                padcfg_pkg::LOAD: begin
                    // Clock stays high from the last bit, reset low on the second cycle
                    cyc_cnt         <= cyc_cnt + 1'b1;
                    serial_resetn_o <= (cyc_cnt != CYC_CNT_W'(1));
                    serial_clock_o  <= (cyc_cnt != CYC_CNT_W'(LOAD_LAST));
                    if (cyc_cnt == CYC_CNT_W'(LOAD_LAST)) begin
                        state <= padcfg_pkg::IDLE;
                    end
                end
                default: begin
                    state <= padcfg_pkg::IDLE;
                end
            endcase
        end
    end

    // Shift on the falling clock so data is settled before each rising edge
    always_ff @(posedge clk) begin
        if (state == padcfg_pkg::START) begin
            stage_1 <= io_ctrl_i[idx_1];
            stage_2 <= io_ctrl_i[idx_2];
        end else if ((state == padcfg_pkg::SHIFT) && serial_clock_o) begin
            stage_1 <= {stage_1[`PADCFG_CTRL_BITS-2:0], 1'b0};
            stage_2 <= {stage_2[`PADCFG_CTRL_BITS-2:0], 1'b0};
        end
    end

endmodule

/* rtl/padcfg_wb_top.sv */
// Wishbone slave top of the pad configuration block
// Turns the bus signals into a register request and ties the register
// file to the serial loader
`timescale 1ns/10ps
`include "padcfg_defines.svh"

module padcfg_wb_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [3:0]              wb_sel_i,
    input  logic [31:0]             wb_adr_i,
    input  logic [31:0]             wb_dat_i,
    input  padcfg_pkg::pad_vec_t    mgmt_gpio_in_i,
    output logic [31:0]             wb_dat_o,
    output logic                    wb_ack_o,
    output padcfg_pkg::pad_vec_t    mgmt_gpio_out_o,
    output padcfg_pkg::pad_vec_t    mgmt_gpio_oe_o,
    output padcfg_pkg::pwr_ctrl_t   pwr_ctrl_o,
    output padcfg_pkg::irq_ena_t    user_irq_ena_o,
    output logic                    jtag_oenb_o,
    output logic                    sdo_oenb_o,
    output logic                    flash_io2_oenb_o,
    output logic                    flash_io3_oenb_o,
    output logic                    serial_clock_o,
    output logic                    serial_resetn_o,
    output logic                    serial_data_1_o,
    output logic                    serial_data_2_o
);

    padcfg_pkg::reg_req_t req;
    padcfg_pkg::io_ctrl_t [`PADCFG_IO_PADS-1:0] io_ctrl;
    logic start;
    logic busy;

    // Only byte lane 0 qualifies a write
    assign req.valid = wb_cyc_i && wb_stb_i;
    assign req.write = wb_we_i && wb_sel_i[0];
    assign req.addr  = wb_adr_i;
    assign req.wdata = wb_dat_i;

    padcfg_regs u_regs (
        .clk              (clk),
        .resetn           (resetn),
        .req_i            (req),
        .busy_i           (busy),
        .mgmt_gpio_in_i   (mgmt_gpio_in_i),
        .rdata_o          (wb_dat_o),
        .ack_o            (wb_ack_o),
        .start_o          (start),
        .io_ctrl_o        (io_ctrl),
        .mgmt_gpio_out_o  (mgmt_gpio_out_o),
        .mgmt_gpio_oe_o   (mgmt_gpio_oe_o),
        .pwr_ctrl_o       (pwr_ctrl_o),
        .user_irq_ena_o   (user_irq_ena_o),
        .jtag_oenb_o      (jtag_oenb_o),
        .sdo_oenb_o       (sdo_oenb_o),
        .flash_io2_oenb_o (flash_io2_oenb_o),
        .flash_io3_oenb_o (flash_io3_oenb_o)
    );

    padcfg_serial_loader u_loader (
        .clk             (clk),
        .resetn          (resetn),
        .start_i         (start),
        .io_ctrl_i       (io_ctrl),
        .busy_o          (busy),
        .serial_clock_o  (serial_clock_o),
        .serial_resetn_o (serial_resetn_o),
        .serial_data_1_o (serial_data_1_o),
        .serial_data_2_o (serial_data_2_o)
    );

endmodule

/* testbench/padcfg_checker.sv */
// Protocol and reset assertions for the pad configuration top
// Attached to every padcfg_wb_top instance by the bind at the end of this file
`timescale 1ns/10ps

module padcfg_checker (
    input logic clk,
    input logic resetn,
    input logic ack_i,
    input logic start_i,
    input logic busy_i,
    input logic serial_clock_i,
    input logic serial_resetn_i
);

    int assert_errors = 0;

    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn) ack_i |=> !ack_i)
        else begin
            $error("ack held high for more than one cycle");
            assert_errors++;
        end

    // The loader only leaves idle on a start pulse from the register file
    busy_after_start: assert property (@(posedge clk) disable iff (!resetn)
        $rose(busy_i) |-> $past(start_i))
        else begin
            $error("busy rose without a start pulse");
            assert_errors++;
        end

    // Load strobe only while the serial clock is held high, first idle cycle excepted
    load_with_clock_high: assert property (@(posedge clk) disable iff (!resetn)
        ($past(resetn) && !serial_resetn_i) |-> serial_clock_i)
        else begin
            $error("serial reset low while serial clock low");
            assert_errors++;
        end

endmodule

bind padcfg_wb_top padcfg_checker u_checker (
    .clk             (clk),
    .resetn          (resetn),
    .ack_i           (wb_ack_o),
    .start_i         (start),
    .busy_i          (busy),
    .serial_clock_i  (serial_clock_o),
    .serial_resetn_i (serial_resetn_o)
);

/* testbench/padcfg_monitor.sv */
// Watches the pad configuration outputs and both serial chains
// Compares them against the register model of the testbench and counts errors
`timescale 1ns/10ps
`include "padcfg_defines.svh"

module padcfg_monitor (
    input logic                                        clk,
    input logic                                        resetn,
    input padcfg_pkg::io_ctrl_t [`PADCFG_IO_PADS-1:0]  model_ctrl_i,
    input padcfg_pkg::pad_vec_t                        model_gpio_out_i,
    input padcfg_pkg::pwr_ctrl_t                       model_pwr_i,
    input padcfg_pkg::irq_ena_t                        model_irq_i,
    input padcfg_pkg::pad_vec_t                        gpio_out_i,
    input padcfg_pkg::pad_vec_t                        gpio_oe_i,
    input padcfg_pkg::pwr_ctrl_t                       pwr_ctrl_i,
    input padcfg_pkg::irq_ena_t                        irq_ena_i,
    input logic [3:0]                                  oenb_i,
    input logic                                        serial_clock_i,
    input logic                                        serial_resetn_i,
    input logic                                        serial_data_1_i,
    input logic                                        serial_data_2_i
);

    localparam int CHAIN_BITS = `PADCFG_IO_PADS_LOW * `PADCFG_CTRL_BITS;
    localparam int W          = `PADCFG_CTRL_BITS;

    int checks = 0;
    int errors = 0;
    int loads_seen = 0;
    int bits_seen = 0;
    logic sclk_prev = 1'b0;
    logic [CHAIN_BITS-1:0] chain_1 = '0;
    logic [CHAIN_BITS-1:0] chain_2 = '0;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic count_failure(input string why);
        errors++;
        $display("%s", why);
    endtask

    // Output enable follows the input-disable bit, oenb the OEB bit of the end pads
    task automatic check_ports();
        padcfg_pkg::pad_vec_t oe_exp;
        logic [3:0] oenb_exp;
        for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
            oe_exp[i] = model_ctrl_i[i][`PADCFG_INP_DIS_BIT];
        end
        oenb_exp[0] = model_ctrl_i[0][`PADCFG_OEB_BIT];
        oenb_exp[1] = model_ctrl_i[1][`PADCFG_OEB_BIT];
        oenb_exp[2] = model_ctrl_i[`PADCFG_IO_PADS-2][`PADCFG_OEB_BIT];
        oenb_exp[3] = model_ctrl_i[`PADCFG_IO_PADS-1][`PADCFG_OEB_BIT];
        compare("gpio out port", 32'(gpio_out_i), 32'(model_gpio_out_i));
        compare("gpio oe port", 32'(gpio_oe_i), 32'(oe_exp));
        compare("oenb ports", 32'(oenb_i), 32'(oenb_exp));
        compare("pwr ctrl port", 32'(pwr_ctrl_i), 32'(model_pwr_i));
        compare("irq enable port", 32'(irq_ena_i), 32'(model_irq_i));
    endtask

    // All serial lines are settled at the falling system clock
    always @(negedge clk) begin
        if (resetn && serial_clock_i && !sclk_prev) begin
            chain_1 = {chain_1[CHAIN_BITS-2:0], serial_data_1_i};
            chain_2 = {chain_2[CHAIN_BITS-2:0], serial_data_2_i};
            bits_seen++;
        end
        if (resetn && !serial_resetn_i && (bits_seen > 0)) begin
            compare("chain bit count", 32'(bits_seen), 32'(CHAIN_BITS));
            // First word shifted sits at the top, pad 5 on chain 1 and pad 6 on chain 2
            for (int p = 0; p < `PADCFG_IO_PADS_LOW; p++) begin
                compare($sformatf("chain 1 pad %0d", `PADCFG_IO_PADS_LOW - 1 - p),
                        32'(chain_1[CHAIN_BITS-1-W*p -: W]),
                        32'(model_ctrl_i[`PADCFG_IO_PADS_LOW-1-p]));
                compare($sformatf("chain 2 pad %0d", `PADCFG_IO_PADS_LOW + p),
                        32'(chain_2[CHAIN_BITS-1-W*p -: W]),
                        32'(model_ctrl_i[`PADCFG_IO_PADS_LOW+p]));
            end
            bits_seen = 0;
            loads_seen++;
        end
        sclk_prev = resetn ? serial_clock_i : 1'b0;
    end

endmodule

/* testbench/tb_padcfg.sv */
// Testbench top of the pad configuration block
// Drives the Wishbone port with LFSR stimulus, keeps the register model
// and leaves the comparing to the monitor
`timescale 1ns/10ps
`include "padcfg_defines.svh"

module tb_padcfg;

    localparam int ACK_WAIT   = 10;
    localparam int BUSY_POLLS = 200;
    localparam int OOR_WAIT   = 20;

    logic        clk;
    logic        resetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    padcfg_pkg::pad_vec_t gpio_in;

    logic [31:0] wb_rdata;
    logic        wb_ack;
    padcfg_pkg::pad_vec_t gpio_out;
    padcfg_pkg::pad_vec_t gpio_oe;
    padcfg_pkg::pwr_ctrl_t pwr;
    padcfg_pkg::irq_ena_t  irq_ena;
    logic [3:0]  oenb;
    logic        sclk;
    logic        sresetn;
    logic        sdata_1;
    logic        sdata_2;

    // Register model
    padcfg_pkg::io_ctrl_t [`PADCFG_IO_PADS-1:0] model_ctrl;
    padcfg_pkg::pwr_ctrl_t model_pwr;
    padcfg_pkg::irq_ena_t  model_irq;
    padcfg_pkg::pad_vec_t  model_gpio_out;

    logic [31:0] lfsr;

    always #50 clk = ~clk;

    padcfg_wb_top u_dut (
        .clk              (clk),
        .resetn           (resetn),
        .wb_cyc_i         (wb_cyc),
        .wb_stb_i         (wb_stb),
        .wb_we_i          (wb_we),
        .wb_sel_i         (wb_sel),
        .wb_adr_i         (wb_adr),
        .wb_dat_i         (wb_dat),
        .mgmt_gpio_in_i   (gpio_in),
        .wb_dat_o         (wb_rdata),
        .wb_ack_o         (wb_ack),
        .mgmt_gpio_out_o  (gpio_out),
        .mgmt_gpio_oe_o   (gpio_oe),
        .pwr_ctrl_o       (pwr),
        .user_irq_ena_o   (irq_ena),
        .jtag_oenb_o      (oenb[0]),
        .sdo_oenb_o       (oenb[1]),
        .flash_io2_oenb_o (oenb[2]),
        .flash_io3_oenb_o (oenb[3]),
        .serial_clock_o   (sclk),
        .serial_resetn_o  (sresetn),
        .serial_data_1_o  (sdata_1),
        .serial_data_2_o  (sdata_2)
    );

    padcfg_monitor u_mon (
        .clk              (clk),
        .resetn           (resetn),
        .model_ctrl_i     (model_ctrl),
        .model_gpio_out_i (model_gpio_out),
        .model_pwr_i      (model_pwr),
        .model_irq_i      (model_irq),
        .gpio_out_i       (gpio_out),
        .gpio_oe_i        (gpio_oe),
        .pwr_ctrl_i       (pwr),
        .irq_ena_i        (irq_ena),
        .oenb_i           (oenb),
        .serial_clock_i   (sclk),
        .serial_resetn_i  (sresetn),
        .serial_data_1_i  (sdata_1),
        .serial_data_2_i  (sdata_2)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Power, IRQ, IODATA or one of the pad config words
    function automatic logic [7:0] pick_offset();
        int idx;
        idx = int'(take_bits(4)) % 15;
        case (idx)
            0: pick_offset = `PADCFG_OFS_PWR;
            1: pick_offset = `PADCFG_OFS_IRQ;
            2: pick_offset = `PADCFG_OFS_IODATA;
            default: pick_offset = 8'(`PADCFG_OFS_IOCFG + 4 * (idx - 3));
        endcase
    endfunction

    // Readback from the model, XFER reads idle
    function automatic logic [31:0] expected_read(input logic [7:0] ofs);
        logic [31:0] v;
        v = '0;
        if (ofs == `PADCFG_OFS_PWR) begin
            v = 32'(model_pwr);
        end else if (ofs == `PADCFG_OFS_IRQ) begin
            v = 32'(model_irq);
        end else if (ofs == `PADCFG_OFS_IODATA) begin
            v = 32'(gpio_in);
        end
        for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
            if (ofs == 8'(`PADCFG_OFS_IOCFG + 4 * i)) begin
                v = 32'(model_ctrl[i]);
            end
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd);
        int n;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_sel <= 4'hf;
        wb_adr <= adr;
        wb_dat <= dat;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_ack && (n < ACK_WAIT));
        if (!wb_ack) begin
            abort_run($sformatf("no ack for address %h within %0d cycles", adr, ACK_WAIT));
        end else begin
            rd = wb_rdata;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end
    endtask

    task automatic write_reg(input logic [7:0] ofs, input logic [31:0] data);
        logic [31:0] rd;
        bus_cycle(1'b1, {`PADCFG_BASE_HI, ofs}, data, rd);
        if (ofs == `PADCFG_OFS_PWR) begin
            model_pwr = data[`PADCFG_PWR_PADS-1:0];
        end else if (ofs == `PADCFG_OFS_IRQ) begin
            model_irq = data[2:0];
        end else if (ofs == `PADCFG_OFS_IODATA) begin
            model_gpio_out = data[`PADCFG_IO_PADS-1:0];
        end
        for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
            if (ofs == 8'(`PADCFG_OFS_IOCFG + 4 * i)) begin
                model_ctrl[i] = data[`PADCFG_CTRL_BITS-1:0];
            end
        end
    endtask

    task automatic read_check(input logic [7:0] ofs);
        logic [31:0] rd;
        bus_cycle(1'b0, {`PADCFG_BASE_HI, ofs}, 32'h0, rd);
        u_mon.compare($sformatf("read offset %h", ofs), rd, expected_read(ofs));
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %-18s done, %0d errors", name, u_mon.errors - mark);
    endtask

    initial begin
        int mark;
        int polls;
        int loads_before;
        int pad;
        logic acked;
        logic [31:0] rd;
        logic [31:0] rnd;
        logic [7:0] ofs;
        clk = 1'b0;
        resetn = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_sel = 4'h0;
        wb_adr = '0;
        wb_dat = '0;
        gpio_in = '0;
        lfsr = 32'h1a74_4dc6;
        model_pwr = '0;
        model_irq = '0;
        model_gpio_out = '0;
        for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
            model_ctrl[i] = ((i < 2) || (i >= `PADCFG_IO_PADS - 2)) ?
                            `PADCFG_CTRL_BIDIR : `PADCFG_CTRL_INPUT;
        end
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        mark = u_mon.errors;
        read_check(`PADCFG_OFS_XFER);
        read_check(`PADCFG_OFS_PWR);
        read_check(`PADCFG_OFS_IRQ);
        read_check(`PADCFG_OFS_IODATA);
        for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
            read_check(8'(`PADCFG_OFS_IOCFG + 4 * i));
        end
        u_mon.check_ports();
        report_test("reset defaults", mark);

        mark = u_mon.errors;
        for (int k = 0; k < 40; k++) begin
            ofs = pick_offset();
            write_reg(ofs, take_bits(32));
            read_check(ofs);
            u_mon.check_ports();
        end
        report_test("random writes", mark);

        mark = u_mon.errors;
        for (int k = 0; k < 8; k++) begin
            rnd = take_bits(`PADCFG_IO_PADS);
            @(posedge clk);
            gpio_in <= rnd[`PADCFG_IO_PADS-1:0];
            read_check(`PADCFG_OFS_IODATA);
        end
        report_test("input sampling", mark);

        mark = u_mon.errors;
        for (int i = 0; i < `PADCFG_IO_PADS; i++) begin
            write_reg(8'(`PADCFG_OFS_IOCFG + 4 * i), take_bits(32));
        end
        loads_before = u_mon.loads_seen;
        write_reg(`PADCFG_OFS_XFER, 32'h1);
        polls = 0;
        do begin
            bus_cycle(1'b0, {`PADCFG_BASE_HI, `PADCFG_OFS_XFER}, 32'h0, rd);
            polls++;
        end while (rd[0] && (polls < BUSY_POLLS));
        if (rd[0]) begin
            abort_run($sformatf("loader still busy after %0d polls", BUSY_POLLS));
        end
        u_mon.compare("chain loads", 32'(u_mon.loads_seen), 32'(loads_before + 1));
        report_test("serial transfer", mark);

        mark = u_mon.errors;
        for (int k = 0; k < 4; k++) begin
            pad = (k < 2) ? k : k + `PADCFG_IO_PADS - 4;
            ofs = 8'(`PADCFG_OFS_IOCFG + 4 * pad);
            write_reg(ofs, take_bits(32));
            read_check(ofs);
            u_mon.check_ports();
        end
        report_test("oenb outputs", mark);

        mark = u_mon.errors;
        acked = 1'b0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= 32'h1200_0004;
        repeat (OOR_WAIT) begin
            @(posedge clk);
            acked = acked | wb_ack;
        end
        if (acked) begin
            u_mon.count_failure("request outside the base address was acknowledged");
        end else begin
            $display("request outside the base address got no ack within %0d cycles",
                     OOR_WAIT);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(posedge clk);
        report_test("out of range", mark);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 u_mon.checks, u_mon.errors, u_dut.u_checker.assert_errors);
        if ((u_mon.errors == 0) && (u_dut.u_checker.assert_errors == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
